// File: conv_args_tests.txt
// six hex fields per record: op then five arguments, unused ones are 0
// op 1 config: mode of_total bias_base tail_base rank_base
// op 2 fill: start_adr count seed
// op 3 expected load: kind (0 bias, 1 tail, 2 rank) adr reg_start reg_size
// op 4 refresh: layer_end flag, runs the expected loads listed before it

// mode 0, 200 output channels in four tiles
1 0 00c8 0010 0020 0030
2 0010 0030 a001 0 0
3 0 0010 01 40 0
3 1 0020 01 20 0
3 1 0021 21 20 0
3 2 0030 01 40 0
4 0 0 0 0 0
3 0 0011 01 40 0
3 1 0022 01 20 0
3 1 0023 21 20 0
3 2 0031 01 40 0
4 0 0 0 0 0
// third tile reads rewritten words
2 0012 0001 b002 0 0
2 0024 0002 b002 0 0
3 0 0012 01 40 0
3 1 0024 01 20 0
3 1 0025 21 20 0
3 2 0032 01 40 0
4 0 0 0 0 0
// partial last tile of 8 rows ends the layer
3 0 0013 01 08 0
3 1 0026 01 08 0
3 2 0033 01 08 0
4 1 0 0 0 0
// mode 1 after a new reset, one tile of 128 rows
1 1 0080 0100 0140 0180
2 0100 0002 c003 0 0
2 0140 0004 c003 0 0
2 0180 0002 c003 0 0
3 0 0100 01 20 0
3 0 0101 21 20 0
3 1 0140 01 10 0
3 1 0141 11 10 0
3 1 0142 21 10 0
3 1 0143 31 10 0
3 2 0180 01 20 0
3 2 0181 21 20 0
4 1 0 0 0 0

// File: all.f
design/conv_cfg_pkg.sv
design/args_mem_pkg.sv
design/args_tile_tracker.sv
design/args_word_sequencer.sv
design/args_mem_arbiter.sv
design/args_buffer.sv
design/conv_args_top.sv
tb/tb_clock_gen.sv
tb/conv_args_tb.sv

// File: Bender.yml
package:
  name: conv_args

sources:
  # packages first, then the design bottom up
  - files:
      - design/conv_cfg_pkg.sv
      - design/args_mem_pkg.sv
      - design/args_tile_tracker.sv
      - design/args_word_sequencer.sv
      - design/args_mem_arbiter.sv
      - design/args_buffer.sv
      - design/conv_args_top.sv

  # testbench, top module conv_args_tb
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/conv_args_tb.sv

// File: tb/conv_args_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_args_tb;

  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 3;
  localparam int REC_FIELDS   = 6;
  localparam int MAX_RECS     = 64;

  localparam logic [63:0] OP_CONFIG  = 64'h1;
  localparam logic [63:0] OP_FILL    = 64'h2;
  localparam logic [63:0] OP_EXPECT  = 64'h3;
  localparam logic [63:0] OP_REFRESH = 64'h4;

  typedef struct packed {
    logic [conv_cfg_pkg::ADR_W-1:0]     adr;
    logic [conv_cfg_pkg::REG_IDX_W-1:0] reg_start;
    logic [conv_cfg_pkg::REG_IDX_W-1:0] reg_size;
  } exp_rec_t;

  logic                            clk;
  logic                            reset;
  conv_cfg_pkg::layer_cfg_t        cfg;
  logic                            refresh;
  args_mem_pkg::buf_wr_t           fill;
  args_mem_pkg::args_load_t        load;
  logic                            tile_done;
  logic                            layer_done;

  logic [63:0]                     tests [REC_FIELDS*MAX_RECS];
  logic [args_mem_pkg::WORD_W-1:0] shadow [2**args_mem_pkg::BUF_DEPTH_LOG2];
  exp_rec_t                        exp_bias [$];
  exp_rec_t                        exp_tail [$];
  exp_rec_t                        exp_rank [$];

  int                              errors;
  int                              checks;
  int                              cycle_count;
  int                              cycle_limit;
  logic                            limit_ready;
  logic                            tile_armed;
  logic                            tile_seen;
  logic                            exp_layer;

  tb_clock_gen #(.PERIOD_NS(40)) u_clock (.clk(clk));

  conv_args_top DUT (
    .clk        (clk),
    .reset      (reset),
    .cfg        (cfg),
    .refresh    (refresh),
    .fill       (fill),
    .load       (load),
    .tile_done  (tile_done),
    .layer_done (layer_done)
  );

  ////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////

  // buffer word built from the seed and the full address
  function automatic logic [63:0] pattern_word(logic [15:0] adr, logic [15:0] seed);
    return {seed, adr, ~adr, seed ^ {adr[7:0], adr[15:8]}};
  endfunction

  task automatic compare_value(string name, logic [63:0] got, logic [63:0] want);
    checks++;
    assert (got === want)
    else
    begin
      errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, want);
    end
  endtask

  // records of one kind come in address order while kinds interleave freely
  task automatic check_load();
    exp_rec_t want;
    logic     have;
    have = 1'b0;
    case (load.kind)
      args_mem_pkg::KIND_BIAS:
        if (exp_bias.size() > 0)
        begin
          want = exp_bias.pop_front();
          have = 1'b1;
        end
      args_mem_pkg::KIND_TAIL:
        if (exp_tail.size() > 0)
        begin
          want = exp_tail.pop_front();
          have = 1'b1;
        end
      args_mem_pkg::KIND_RANK:
        if (exp_rank.size() > 0)
        begin
          want = exp_rank.pop_front();
          have = 1'b1;
        end
      default:
        have = 1'b0;
    endcase
    checks++;
    assert (have)
    else
    begin
      errors++;
      $display("extra load record of kind %0d at address %h", int'(load.kind), load.adr);
    end
    if (have)
    begin
      compare_value("load.adr", 64'(load.adr), 64'(want.adr));
      compare_value("load.reg_start", 64'(load.reg_start), 64'(want.reg_start));
      compare_value("load.reg_size", 64'(load.reg_size), 64'(want.reg_size));
      compare_value("load.word", load.word,
                    shadow[want.adr[args_mem_pkg::BUF_DEPTH_LOG2-1:0]]);
    end
  endtask

  // advance one cycle and look at the outputs on the falling edge
  task automatic tick();
    @(negedge clk);
    if (load.valid === 1'b1)
    begin
      checks++;
      assert (tile_armed)
      else
      begin
        errors++;
        $display("load record at address %h came without a refresh", load.adr);
      end
      if (tile_armed)
        check_load();
    end
    if (tile_done === 1'b1)
    begin
      checks++;
      assert (tile_armed)
      else
      begin
        errors++;
        $display("tile_done pulsed without a refresh");
      end
      compare_value("layer_done", 64'(layer_done), 64'(exp_layer));
      tile_seen  = 1'b1;
      tile_armed = 1'b0;
    end
    else
    begin
      checks++;
      assert (layer_done !== 1'b1)
      else
      begin
        errors++;
        $display("layer_done pulsed without tile_done");
      end
    end
  endtask

  ////////////////////////////////////////
  // test record actions
  ////////////////////////////////////////

  // config is only sampled while reset is high
  task automatic apply_config(logic mode, logic [15:0] of_total, logic [15:0] bias_base,
                              logic [15:0] tail_base, logic [15:0] rank_base);
    tick();
    cfg.mode      = conv_cfg_pkg::tile_mode_e'(mode);
    cfg.of_total  = of_total;
    cfg.bias_base = bias_base;
    cfg.tail_base = tail_base;
    cfg.rank_base = rank_base;
    reset         = 1'b1;
    tile_armed    = 1'b0;
    repeat (RESET_CYCLES) tick();
    reset = 1'b0;
    repeat (IDLE_CYCLES) tick();
  endtask

  task automatic fill_range(logic [15:0] start, int count, logic [15:0] seed);
    logic [15:0] adr;
    for (int i = 0; i < count; i++)
    begin
      adr = start + 16'(i);
      tick();
      fill.wr   = 1'b1;
      fill.adr  = adr;
      fill.data = pattern_word(adr, seed);
      shadow[adr[args_mem_pkg::BUF_DEPTH_LOG2-1:0]] = fill.data;
    end
    tick();
    fill = '0;
  endtask

  task automatic push_expect(logic [1:0] kind, logic [15:0] adr, logic [7:0] reg_start,
                             logic [7:0] reg_size);
    exp_rec_t rec;
    rec = '{adr: adr, reg_start: reg_start, reg_size: reg_size};
    case (kind)
      2'd0: exp_bias.push_back(rec);
      2'd1: exp_tail.push_back(rec);
      2'd2: exp_rank.push_back(rec);
      default:
      begin
        errors++;
        $display("expected record with unknown kind %0d", kind);
      end
    endcase
  endtask

  // one refresh strobe and the wait for the tile to end
  task automatic run_refresh(logic layer_end);
    tick();
    exp_layer  = layer_end;
    tile_seen  = 1'b0;
    tile_armed = 1'b1;
    refresh    = 1'b1;
    tick();
    refresh = 1'b0;
    while (!tile_seen)
      tick();
    checks++;
    assert (exp_bias.size() == 0 && exp_tail.size() == 0 && exp_rank.size() == 0)
    else
    begin
      errors++;
      $display("tile ended with load records missing: bias %0d, tail %0d, rank %0d",
               exp_bias.size(), exp_tail.size(), exp_rank.size());
      exp_bias.delete();
      exp_tail.delete();
      exp_rank.delete();
    end
    repeat (IDLE_CYCLES) tick();
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    logic [63:0] rec [REC_FIELDS];
    int          n_recs;
    reset       = 1'b1;
    cfg         = '0;
    refresh     = 1'b0;
    fill        = '0;
    errors      = 0;
    checks      = 0;
    tile_armed  = 1'b0;
    tile_seen   = 1'b0;
    exp_layer   = 1'b0;
    limit_ready = 1'b0;
    for (int i = 0; i < REC_FIELDS * MAX_RECS; i++)
      tests[i] = '0;
    $readmemh("conv_args_tests.txt", tests);

    // op 0 ends the list
    n_recs = 0;
    while (n_recs < MAX_RECS && tests[n_recs*REC_FIELDS] != '0)
      n_recs++;

    cycle_limit = 20;
    for (int r = 0; r < n_recs; r++)
    begin
      case (tests[r*REC_FIELDS])
        OP_CONFIG: cycle_limit += RESET_CYCLES + IDLE_CYCLES + 2;
        OP_FILL:   cycle_limit += int'(tests[r*REC_FIELDS+2]) + 2;
        OP_EXPECT: cycle_limit += 4;
        default:   cycle_limit += IDLE_CYCLES + 8;
      endcase
    end
    limit_ready = 1'b1;

    for (int r = 0; r < n_recs; r++)
    begin
      for (int i = 0; i < REC_FIELDS; i++)
        rec[i] = tests[r*REC_FIELDS+i];
      case (rec[0])
        OP_CONFIG:
          apply_config(rec[1][0], rec[2][15:0], rec[3][15:0], rec[4][15:0], rec[5][15:0]);
        OP_FILL:
          fill_range(rec[1][15:0], int'(rec[2]), rec[3][15:0]);
        OP_EXPECT:
          push_expect(rec[1][1:0], rec[2][15:0], rec[3][7:0], rec[4][7:0]);
        OP_REFRESH:
          run_refresh(rec[1][0]);
        default:
        begin
          errors++;
          $display("unknown test record op %h at record %0d", rec[0], r);
        end
      endcase
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // watchdog counts rising edges up to the limit from the test list
  initial
  begin
    cycle_count = 0;
    wait (limit_ready === 1'b1);
    while (cycle_count < cycle_limit)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // free running, first rising edge after half a period
  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: design/conv_args_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_args_top (
  input  logic                          clk,
  input  logic                          reset,
  input  conv_cfg_pkg::layer_cfg_t      cfg,
  input  logic                          refresh,
  input  args_mem_pkg::buf_wr_t         fill,
  output args_mem_pkg::args_load_t      load,
  output logic                          tile_done,
  output logic                          layer_done
);

  logic [conv_cfg_pkg::COUNT_W-1:0]     tile_start;
  logic [conv_cfg_pkg::COUNT_W-1:0]     tile_size;
  logic [conv_cfg_pkg::SHIFT_W-1:0]     args_per_reg_log2;
  logic                                 bias_fin;
  logic                                 tail_fin;
  logic                                 rank_fin;
  logic [2:0]                           grant;
  args_mem_pkg::buf_req_t               bias_req;
  args_mem_pkg::buf_req_t               tail_req;
  args_mem_pkg::buf_req_t               rank_req;
  logic [conv_cfg_pkg::REG_IDX_W-1:0]   bias_reg_start;
  logic [conv_cfg_pkg::REG_IDX_W-1:0]   bias_reg_size;
  logic [conv_cfg_pkg::REG_IDX_W-1:0]   tail_reg_start;
  logic [conv_cfg_pkg::REG_IDX_W-1:0]   tail_reg_size;
  logic [conv_cfg_pkg::REG_IDX_W-1:0]   rank_reg_start;
  logic [conv_cfg_pkg::REG_IDX_W-1:0]   rank_reg_size;
  args_mem_pkg::reg_win_t               bias_win;
  args_mem_pkg::reg_win_t               tail_win;
  args_mem_pkg::reg_win_t               rank_win;
  args_mem_pkg::buf_req_t               rd_req;
  logic [args_mem_pkg::WORD_W-1:0]      rd_data;

  // tile height only matters inside the tracker
  args_tile_tracker u_tracker (
    .clk               (clk),
    .reset             (reset),
    .cfg               (cfg),
    .word_fin          ({rank_fin, tail_fin, bias_fin}),
    .tile_start        (tile_start),
    .tile_size         (tile_size),
    .row_num           (),
    .args_per_reg_log2 (args_per_reg_log2),
    .tile_done         (tile_done),
    .layer_done        (layer_done)
  );

  ////////////////////////////////////////
  // one sequencer per argument kind
  ////////////////////////////////////////

  args_word_sequencer #(
    .KIND          (args_mem_pkg::KIND_BIAS),
    .PER_WORD_LOG2 (conv_cfg_pkg::BIAS_PER_WORD_LOG2)
  ) u_seq_bias (
    .clk               (clk),
    .reset             (reset),
    .refresh           (refresh),
    .base_adr          (cfg.bias_base),
    .tile_start        (tile_start),
    .tile_size         (tile_size),
    .args_per_reg_log2 (args_per_reg_log2),
    .tile_done         (tile_done),
    .grant             (grant[0]),
    .req               (bias_req),
    .reg_start         (bias_reg_start),
    .reg_size          (bias_reg_size),
    .word_fin          (bias_fin)
  );

  args_word_sequencer #(
    .KIND          (args_mem_pkg::KIND_TAIL),
    .PER_WORD_LOG2 (conv_cfg_pkg::TAIL_PER_WORD_LOG2)
  ) u_seq_tail (
    .clk               (clk),
    .reset             (reset),
    .refresh           (refresh),
    .base_adr          (cfg.tail_base),
    .tile_start        (tile_start),
    .tile_size         (tile_size),
    .args_per_reg_log2 (args_per_reg_log2),
    .tile_done         (tile_done),
    .grant             (grant[1]),
    .req               (tail_req),
    .reg_start         (tail_reg_start),
    .reg_size          (tail_reg_size),
    .word_fin          (tail_fin)
  );

  args_word_sequencer #(
    .KIND          (args_mem_pkg::KIND_RANK),
    .PER_WORD_LOG2 (conv_cfg_pkg::RANK_PER_WORD_LOG2)
  ) u_seq_rank (
    .clk               (clk),
    .reset             (reset),
    .refresh           (refresh),
    .base_adr          (cfg.rank_base),
    .tile_start        (tile_start),
    .tile_size         (tile_size),
    .args_per_reg_log2 (args_per_reg_log2),
    .tile_done         (tile_done),
    .grant             (grant[2]),
    .req               (rank_req),
    .reg_start         (rank_reg_start),
    .reg_size          (rank_reg_size),
    .word_fin          (rank_fin)
  );

  assign bias_win = '{reg_start: bias_reg_start, reg_size: bias_reg_size};
  assign tail_win = '{reg_start: tail_reg_start, reg_size: tail_reg_size};
  assign rank_win = '{reg_start: rank_reg_start, reg_size: rank_reg_size};

  ////////////////////////////////////////
  // shared buffer port
  ////////////////////////////////////////

  args_mem_arbiter u_arbiter (
    .clk      (clk),
    .reset    (reset),
    .req_bias (bias_req),
    .req_tail (tail_req),
    .req_rank (rank_req),
    .win_bias (bias_win),
    .win_tail (tail_win),
    .win_rank (rank_win),
    .grant    (grant),
    .rd_req   (rd_req),
    .rd_data  (rd_data),
    .load     (load)
  );

  args_buffer u_buffer (
    .clk     (clk),
    .wr      (fill),
    .rd_req  (rd_req),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: design/args_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module args_buffer (
  input  logic                                  clk,
  input  args_mem_pkg::buf_wr_t                 wr,
  input  args_mem_pkg::buf_req_t                rd_req,
  output logic [args_mem_pkg::WORD_W-1:0]       rd_data
);

  logic [args_mem_pkg::WORD_W-1:0] mem [2**args_mem_pkg::BUF_DEPTH_LOG2];

  // fill port, one word per strobe
  always_ff @(posedge clk)
  begin
    if (wr.wr)
      mem[wr.adr[args_mem_pkg::BUF_DEPTH_LOG2-1:0]] <= wr.data;
  end

  // registered read, data valid the cycle after rd
  always_ff @(posedge clk)
  begin
    if (rd_req.rd)
      rd_data <= mem[rd_req.adr[args_mem_pkg::BUF_DEPTH_LOG2-1:0]];
  end

endmodule

`default_nettype wire

// File: design/args_mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module args_mem_arbiter (
  input  logic                                  clk,
  input  logic                                  reset,
  input  args_mem_pkg::buf_req_t                req_bias,
  input  args_mem_pkg::buf_req_t                req_tail,
  input  args_mem_pkg::buf_req_t                req_rank,
  input  args_mem_pkg::reg_win_t                win_bias,
  input  args_mem_pkg::reg_win_t                win_tail,
  input  args_mem_pkg::reg_win_t                win_rank,
  output logic [2:0]                            grant,
  output args_mem_pkg::buf_req_t                rd_req,
  input  logic [args_mem_pkg::WORD_W-1:0]       rd_data,
  output args_mem_pkg::args_load_t              load
);

  logic [2:0]                           rd_vec;
  logic [1:0]                           last_idx;
  logic [1:0]                           gnt_idx;
  logic                                 gnt_any;
  logic [conv_cfg_pkg::ADR_W-1:0]       gnt_adr;
  args_mem_pkg::reg_win_t               gnt_win;
  logic                                 valid_q;
  args_mem_pkg::args_kind_e             kind_q;
  logic [conv_cfg_pkg::ADR_W-1:0]       adr_q;
  args_mem_pkg::reg_win_t               win_q;

  // bit index matches the kind encoding
  assign rd_vec = {req_rank.rd, req_tail.rd, req_bias.rd};

  ////////////////////////////////////////
  // round robin pick
  ////////////////////////////////////////

  // search starts right after the last winner
  always_comb
  begin
    int cand;
    gnt_any = 1'b0;
    gnt_idx = last_idx;
    for (int step = 1; step <= 3; step++)
    begin
      cand = int'(last_idx) + step;
      if (cand >= 3)
        cand = cand - 3;
      if (!gnt_any && rd_vec[cand])
      begin
        gnt_any = 1'b1;
        gnt_idx = cand[1:0];
      end
    end
  end

  assign grant = gnt_any ? (3'b001 << gnt_idx) : 3'b000;

  always_comb
  begin
    case (gnt_idx)
      2'd1:
      begin
        gnt_adr = req_tail.adr;
        gnt_win = win_tail;
      end
      2'd2:
      begin
        gnt_adr = req_rank.adr;
        gnt_win = win_rank;
      end
      default:
      begin
        gnt_adr = req_bias.adr;
        gnt_win = win_bias;
      end
    endcase
  end

  assign rd_req = '{rd: gnt_any, adr: gnt_adr};

  ////////////////////////////////////////
  // load record
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_q  <= 1'b0;
      last_idx <= 2'd2;
    end
    else
    begin
      valid_q <= gnt_any;
      if (gnt_any)
        last_idx <= gnt_idx;
    end
  end

  always_ff @(posedge clk)
  begin
    kind_q <= args_mem_pkg::args_kind_e'(gnt_idx);
    adr_q  <= gnt_adr;
    win_q  <= gnt_win;
  end

  // buffer data arrives one cycle after the read, aligned with the held fields
  assign load = '{
    valid:     valid_q,
    kind:      kind_q,
    adr:       adr_q,
    reg_start: win_q.reg_start,
    reg_size:  win_q.reg_size,
    word:      rd_data
  };

endmodule

`default_nettype wire

// File: design/args_word_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module args_word_sequencer #(
  parameter args_mem_pkg::args_kind_e KIND = args_mem_pkg::KIND_BIAS,
  parameter int PER_WORD_LOG2 =
    (KIND == args_mem_pkg::KIND_TAIL) ? conv_cfg_pkg::TAIL_PER_WORD_LOG2 :
    (KIND == args_mem_pkg::KIND_RANK) ? conv_cfg_pkg::RANK_PER_WORD_LOG2 :
                                        conv_cfg_pkg::BIAS_PER_WORD_LOG2
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 refresh,
  input  logic [conv_cfg_pkg::ADR_W-1:0]       base_adr,
  input  logic [conv_cfg_pkg::COUNT_W-1:0]     tile_start,
  input  logic [conv_cfg_pkg::COUNT_W-1:0]     tile_size,
  input  logic [conv_cfg_pkg::SHIFT_W-1:0]     args_per_reg_log2,
  input  logic                                 tile_done,
  input  logic                                 grant,
  output args_mem_pkg::buf_req_t               req,
  output logic [conv_cfg_pkg::REG_IDX_W-1:0]   reg_start,
  output logic [conv_cfg_pkg::REG_IDX_W-1:0]   reg_size,
  output logic                                 word_fin
);

  logic                                 active;
  logic [conv_cfg_pkg::COUNT_W-1:0]     word_cnt;
  logic [conv_cfg_pkg::ADR_W-1:0]       base_q;
  logic [conv_cfg_pkg::COUNT_W-1:0]     span_begin;
  logic [conv_cfg_pkg::COUNT_W-1:0]     span_end;
  logic [conv_cfg_pkg::COUNT_W-1:0]     size_args;
  logic [conv_cfg_pkg::COUNT_W-1:0]     size_regs;
  logic                                 last_word;

  ////////////////////////////////////////
  // word window within the tile
  ////////////////////////////////////////

  // arguments of the tile covered before and through the current word
  assign span_begin = (word_cnt - 1'b1) << PER_WORD_LOG2;
  assign span_end   = word_cnt << PER_WORD_LOG2;
  assign last_word  = active && (span_end >= tile_size);

  // a partial last word only loads the arguments left in the tile
  assign size_args = (span_end > tile_size) ? (tile_size - span_begin)
                                            : (span_end - span_begin);
  assign size_regs = size_args >> args_per_reg_log2;
  assign reg_size  = size_regs[conv_cfg_pkg::REG_IDX_W-1:0];

  // words of earlier tiles are skipped from the layer base
  assign req = '{
    rd:  active,
    adr: base_q + ((tile_start - 1'b1) >> PER_WORD_LOG2) + word_cnt - 1'b1
  };

  ////////////////////////////////////////
  // word loop
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      base_q    <= base_adr;
      active    <= 1'b0;
      word_cnt  <= 1;
      reg_start <= 1;
      word_fin  <= 1'b0;
    end
    else
    begin
      if (refresh)
        active <= 1'b1;
      else if (grant && last_word)
        active <= 1'b0;

      // step only on a granted read
      if (grant && active)
      begin
        if (last_word)
        begin
          word_cnt  <= 1;
          reg_start <= 1;
        end
        else
        begin
          word_cnt  <= word_cnt + 1'b1;
          reg_start <= reg_start + reg_size;
        end
      end

      if (grant && last_word)
        word_fin <= 1'b1;
      else if (tile_done)
        word_fin <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: design/args_tile_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module args_tile_tracker (
  input  logic                                 clk,
  input  logic                                 reset,
  input  conv_cfg_pkg::layer_cfg_t             cfg,
  input  logic [2:0]                           word_fin,
  output logic [conv_cfg_pkg::COUNT_W-1:0]     tile_start,
  output logic [conv_cfg_pkg::COUNT_W-1:0]     tile_size,
  output logic [conv_cfg_pkg::COUNT_W-1:0]     row_num,
  output logic [conv_cfg_pkg::SHIFT_W-1:0]     args_per_reg_log2,
  output logic                                 tile_done,
  output logic                                 layer_done
);

  conv_cfg_pkg::tile_mode_e             mode_q;
  logic [conv_cfg_pkg::COUNT_W-1:0]     of_total_q;
  logic                                 advance;
  logic                                 last_tile;

  // layer config is captured while reset is held
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mode_q     <= cfg.mode;
      of_total_q <= cfg.of_total;
    end
  end

  assign row_num = (mode_q == conv_cfg_pkg::MODE_ROW128) ? conv_cfg_pkg::ROW_NUM_MODE1
                                                         : conv_cfg_pkg::ROW_NUM_MODE0;
  assign args_per_reg_log2 = (mode_q == conv_cfg_pkg::MODE_ROW128) ?
                             conv_cfg_pkg::ARGS_PER_REG_LOG2_MODE1 :
                             conv_cfg_pkg::ARGS_PER_REG_LOG2_MODE0;

  // tile starts are 1-based, so the last tile is the one that reaches past of_total
  assign last_tile = (tile_start + row_num) > of_total_q;
  assign tile_size = last_tile ? (of_total_q - tile_start + 1'b1) : row_num;

  // tile_done holds the sequencer fins for one more cycle, so step once only
  assign advance = (&word_fin) && !tile_done;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      tile_start <= 1;
      tile_done  <= 1'b0;
      layer_done <= 1'b0;
    end
    else
    begin
      tile_done  <= advance;
      layer_done <= advance && last_tile;
      if (advance)
      begin
        if (last_tile)
          tile_start <= 1;
        else
          tile_start <= tile_start + row_num;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/args_mem_pkg.sv
`default_nettype none

package args_mem_pkg;

  localparam int WORD_W         = 64;
  localparam int BUF_DEPTH_LOG2 = 10;

  typedef enum logic [1:0] {
    KIND_BIAS = 2'd0,
    KIND_TAIL = 2'd1,
    KIND_RANK = 2'd2
  } args_kind_e;

  typedef struct packed {
    logic                           rd;
    logic [conv_cfg_pkg::ADR_W-1:0] adr;
  } buf_req_t;

  // register window covered by one word
  typedef struct packed {
    logic [conv_cfg_pkg::REG_IDX_W-1:0] reg_start;
    logic [conv_cfg_pkg::REG_IDX_W-1:0] reg_size;
  } reg_win_t;

  typedef struct packed {
    logic                               valid;
    args_kind_e                         kind;
    logic [conv_cfg_pkg::ADR_W-1:0]     adr;
    logic [conv_cfg_pkg::REG_IDX_W-1:0] reg_start;
    logic [conv_cfg_pkg::REG_IDX_W-1:0] reg_size;
    logic [WORD_W-1:0]                  word;
  } args_load_t;

  typedef struct packed {
    logic                           wr;
    logic [conv_cfg_pkg::ADR_W-1:0] adr;
    logic [WORD_W-1:0]              data;
  } buf_wr_t;

endpackage

`default_nettype wire

// File: design/conv_cfg_pkg.sv
`default_nettype none

package conv_cfg_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int ADR_W     = 16;
  localparam int COUNT_W   = 16;
  localparam int REG_IDX_W = 8;

  // shift amount for arguments per register
  localparam int SHIFT_W = 2;

  ////////////////////////////////////////
  // tiling
  ////////////////////////////////////////

  // output channels per tile
  localparam logic [COUNT_W-1:0] ROW_NUM_MODE0 = 64;
  localparam logic [COUNT_W-1:0] ROW_NUM_MODE1 = 128;

  // one argument per register in mode 0, two in mode 1
  localparam logic [SHIFT_W-1:0] ARGS_PER_REG_LOG2_MODE0 = 0;
  localparam logic [SHIFT_W-1:0] ARGS_PER_REG_LOG2_MODE1 = 1;

  // arguments packed into one buffer word
  localparam int BIAS_PER_WORD_LOG2 = 6;
  localparam int TAIL_PER_WORD_LOG2 = 5;
  localparam int RANK_PER_WORD_LOG2 = 6;

  typedef enum logic {
    MODE_ROW64  = 1'b0,
    MODE_ROW128 = 1'b1
  } tile_mode_e;

  typedef struct packed {
    tile_mode_e         mode;
    logic [COUNT_W-1:0] of_total;
    logic [ADR_W-1:0]   bias_base;
    logic [ADR_W-1:0]   tail_base;
    logic [ADR_W-1:0]   rank_base;
  } layer_cfg_t;

endpackage

`default_nettype wire
